// ==== rtl/fetch.sv ====
// Top level of the fetch stage, wiring the PC unit, instruction store and hazard logic to the pipeline.
`timescale 1ns/1ps
`default_nettype none
module fetch (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              stall,
   input  logic [fetchPkg::AddrWidth-1:0]    newPc,
   input  fetchPkg::stageInfo_t              stageD,
   input  fetchPkg::stageInfo_t              stageX,
   input  fetchPkg::stageInfo_t              stageM,
   input  fetchPkg::stageInfo_t              stageW,
   input  logic                              loadEn,
   input  logic [fetchPkg::MemAddrWidth-1:0] loadAddr,
   input  logic [fetchPkg::InstrWidth-1:0]   loadData,
   output fetchPkg::fetchOut_t               fetchOut,
   output fetchPkg::fwdSel_t                 fwdA,
   output fetchPkg::fwdSel_t                 fwdB,
   output logic                              err
);

   // Handshake between the PC unit and the store.
   fetchPkg::memReq_t               memReq;
   fetchPkg::memRsp_t               memRsp;
   // Word strobe from the store and the resolution sent back to the PC unit.
   logic                            fetchedValid;
   logic [fetchPkg::InstrWidth-1:0] fetchedWord;
   logic                            accept;
   logic                            hold;
   logic                            halted;
   logic [fetchPkg::AddrWidth-1:0]  incPc;

   // The writeback stage branch bit selects the redirect.
   pcUnit uPc (
      .clk(clk), .rstN(rstN), .stall(stall), .newPc(newPc), .branchW(stageW.branch),
      .accept(accept), .hold(hold), .halted(halted), .memReq(memReq),
      .memAck(memRsp.ack), .incPc(incPc), .err(err)
   );

   instrMem uMem (
      .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .memReq(memReq), .memRsp(memRsp), .stall(stall),
      .fetchedValid(fetchedValid), .fetchedWord(fetchedWord)
   );

   hazardDetect uHazard (
      .clk(clk), .rstN(rstN), .fetchedValid(fetchedValid), .fetchedWord(fetchedWord),
      .stageD(stageD), .stageX(stageX), .stageM(stageM), .stageW(stageW),
      .incPc(incPc), .accept(accept), .hold(hold), .halted(halted),
      .fetchOut(fetchOut), .fwdA(fwdA), .fwdB(fwdB)
   );

endmodule
`default_nettype wire

// ==== rtl/fetchPkg.sv ====
// Holds the widths, opcodes, latency constants and structs that every fetch stage file uses by scoped name.
package fetchPkg;

   // Machine widths of the 16-bit instruction set.
   localparam int AddrWidth   = 16;
   localparam int InstrWidth  = 16;
   localparam int RegIdxWidth = 3;

   // Geometry of the instruction store and of the modeled cache line.
   localparam int MemWords     = 256;
   localparam int MemAddrWidth = $clog2(MemWords);
   localparam int LineWords    = 8;
   // Byte offset bits inside one line, the word offset plus the byte bit.
   localparam int LineOffWidth = $clog2(LineWords) + 1;
   localparam int LineTagWidth = AddrWidth - LineOffWidth;

   // Cycles from request to acknowledge for the two cases of the latency model.
   localparam int MissLatency = 4;
   localparam int HitLatency  = 1;
   localparam int LatCntWidth = $clog2(MissLatency + 1);
   typedef logic [LatCntWidth-1:0] latCnt_t;

   // The opcode sits in the top five bits of every instruction.
   localparam int OpcodeWidth = 5;
   localparam logic [OpcodeWidth-1:0] OpHalt = 5'b00000;
   localparam logic [OpcodeWidth-1:0] OpNop  = 5'b00001;
   localparam logic [InstrWidth-1:0]  NopInstr = {OpNop, {(InstrWidth-OpcodeWidth){1'b0}}};

   // Low bit positions of the two source register fields.
   localparam int RsLsb = 8;
   localparam int RtLsb = 5;

   // Writeback select value that marks a load in a later stage.
   localparam logic [1:0] WbSelLoad = 2'b01;

   // Status of one later pipeline stage as seen by fetch.
   typedef struct packed {
      logic                   regWrt;
      logic [RegIdxWidth-1:0] wrtReg;
      logic                   branch;
      logic [1:0]             wbSel;
   } stageInfo_t;

   // One-hot forwarding select for a single source operand.
   typedef enum logic [4:0] {
      fwdNone = 5'b00001,
      fwdD    = 5'b00010,
      fwdX    = 5'b00100,
      fwdM    = 5'b01000,
      fwdW    = 5'b10000
   } fwdSel_t;

   // Word handed to decode, with its end-of-fetch marker.
   typedef struct packed {
      logic                  valid;
      logic [InstrWidth-1:0] instr;
      logic [AddrWidth-1:0]  incPc;
   } fetchOut_t;

   // Request and response halves of the four-phase handshake.
   typedef struct packed {
      logic                 req;
      logic [AddrWidth-1:0] addr;
   } memReq_t;

   typedef struct packed {
      logic                  ack;
      logic [InstrWidth-1:0] data;
   } memRsp_t;

endpackage

// ==== rtl/hazardDetect.sv ====
// Checks a fetched word against later stages, inserts a no-op on hazards and builds forwarding selects.
`timescale 1ns/1ps
`default_nettype none
module hazardDetect (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic                            fetchedValid,
   input  logic [fetchPkg::InstrWidth-1:0] fetchedWord,
   input  fetchPkg::stageInfo_t            stageD,
   input  fetchPkg::stageInfo_t            stageX,
   input  fetchPkg::stageInfo_t            stageM,
   input  fetchPkg::stageInfo_t            stageW,
   input  logic [fetchPkg::AddrWidth-1:0]  incPc,
   output logic                            accept,
   output logic                            hold,
   output logic                            halted,
   output fetchPkg::fetchOut_t             fetchOut,
   output fetchPkg::fwdSel_t               fwdA,
   output fetchPkg::fwdSel_t               fwdB
);

   logic [fetchPkg::OpcodeWidth-1:0] opcode;
   logic [fetchPkg::RegIdxWidth-1:0] rs;
   logic [fetchPkg::RegIdxWidth-1:0] rt;
   logic                             readsSrc;
   logic                             isHalt;
   logic                             branchHaz;
   logic                             loadUseHaz;
   logic                             hazard;
   fetchPkg::fwdSel_t                fwdANext;
   fetchPkg::fwdSel_t                fwdBNext;
   logic                             validQ;
   logic [fetchPkg::InstrWidth-1:0]  instrQ;
   logic [fetchPkg::AddrWidth-1:0]   incPcQ;
   logic                             haltedQ;
   fetchPkg::fwdSel_t                fwdAQ;
   fetchPkg::fwdSel_t                fwdBQ;

   // Opcode and source fields sit at fixed positions in every format.
   assign opcode = fetchedWord[fetchPkg::InstrWidth-1 -: fetchPkg::OpcodeWidth];
   assign rs     = fetchedWord[fetchPkg::RsLsb +: fetchPkg::RegIdxWidth];
   assign rt     = fetchedWord[fetchPkg::RtLsb +: fetchPkg::RegIdxWidth];

   // HALT and NOP carry no source registers.
   assign isHalt   = (opcode == fetchPkg::OpHalt);
   assign readsSrc = !isHalt && (opcode != fetchPkg::OpNop);

   // A branch still in flight before writeback makes the fetched word uncertain.
   assign branchHaz = (stageD.branch || stageX.branch || stageM.branch) && !stageW.branch;

   // A load one stage ahead cannot forward in time to this word.
   assign loadUseHaz = (stageD.wbSel == fetchPkg::WbSelLoad) && stageD.regWrt && readsSrc &&
                       ((stageD.wrtReg == rs) || (stageD.wrtReg == rt));

   assign hazard = branchHaz || loadUseHaz;
   assign accept = fetchedValid && !hazard;
   assign hold   = fetchedValid && hazard;

   // Picks the youngest writer of a source, searching D, X, M and then W.
   function automatic fetchPkg::fwdSel_t pickFwd(input logic [fetchPkg::RegIdxWidth-1:0] src);
      fetchPkg::fwdSel_t sel;
      if (!readsSrc || hazard) begin
         sel = fetchPkg::fwdNone;
      end else if (stageD.regWrt && (stageD.wrtReg == src)) begin
         sel = fetchPkg::fwdD;
      end else if (stageX.regWrt && (stageX.wrtReg == src)) begin
         sel = fetchPkg::fwdX;
      end else if (stageM.regWrt && (stageM.wrtReg == src)) begin
         sel = fetchPkg::fwdM;
      end else if (stageW.regWrt && (stageW.wrtReg == src)) begin
         sel = fetchPkg::fwdW;
      end else begin
         sel = fetchPkg::fwdNone;
      end
      return sel;
   endfunction

   assign fwdANext = pickFwd(rs);
   assign fwdBNext = pickFwd(rt);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         validQ  <= 1'b0;
         haltedQ <= 1'b0;
         fwdAQ   <= fetchPkg::fwdNone;
         fwdBQ   <= fetchPkg::fwdNone;
      end else begin
         // Valid is the one-cycle end marker of each fetch.
         validQ <= fetchedValid;
         if (fetchedValid) begin
            fwdAQ <= fwdANext;
            fwdBQ <= fwdBNext;
         end
         // Only a halt that actually went to decode stops the stage.
         if (accept && isHalt) begin
            haltedQ <= 1'b1;
         end
      end
   end

   // A hazard replaces the word with a no-op; incPc still names the fetch address.
   always_ff @(posedge clk) begin
      if (fetchedValid) begin
         instrQ <= hazard ? fetchPkg::NopInstr : fetchedWord;
         incPcQ <= incPc;
      end
   end

   assign fetchOut.valid = validQ;
   assign fetchOut.instr = instrQ;
   assign fetchOut.incPc = incPcQ;
   assign fwdA           = fwdAQ;
   assign fwdB           = fwdBQ;
   assign halted         = haltedQ;

   // Each fetch ends with exactly one cycle of valid, never two in a row.
   validOneCycle: assert property (@(posedge clk) disable iff (!rstN)
      fetchOut.valid |=> !fetchOut.valid);

   // After a halt is delivered the sequencer must never bring another word.
   noWordAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
      halted |-> !fetchedValid);

endmodule
`default_nettype wire

// ==== rtl/instrMem.sv ====
// Instruction store with a load port and a line-hit latency model that answers four-phase requests.
`timescale 1ns/1ps
`default_nettype none
module instrMem (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic                              loadEn,
   input  logic [fetchPkg::MemAddrWidth-1:0] loadAddr,
   input  logic [fetchPkg::InstrWidth-1:0]   loadData,
   input  fetchPkg::memReq_t                 memReq,
   output fetchPkg::memRsp_t                 memRsp,
   input  logic                              stall,
   output logic                              fetchedValid,
   output logic [fetchPkg::InstrWidth-1:0]   fetchedWord
);

   logic [fetchPkg::InstrWidth-1:0]   mem [fetchPkg::MemWords];
   logic [fetchPkg::MemAddrWidth-1:0] wordAddr;
   logic [fetchPkg::LineTagWidth-1:0] reqLine;
   logic [fetchPkg::LineTagWidth-1:0] lastLineQ;
   logic                              lastLineValidQ;
   logic                              lineHit;
   fetchPkg::latCnt_t                 latCntQ;
   fetchPkg::latCnt_t                 latTarget;
   logic                              latDone;
   logic                              capture;
   logic                              ackQ;
   logic                              pendingQ;
   logic [fetchPkg::InstrWidth-1:0]   dataQ;

   // Byte addresses drop bit zero to index words; upper bits beyond the store wrap.
   assign wordAddr = memReq.addr[fetchPkg::MemAddrWidth:1];
   assign reqLine  = memReq.addr[fetchPkg::AddrWidth-1:fetchPkg::LineOffWidth];

   // A hit needs a previous fetch in the same line, so the first fetch always misses.
   assign lineHit   = lastLineValidQ && (reqLine == lastLineQ);
   assign latTarget = lineHit ? fetchPkg::latCnt_t'(fetchPkg::HitLatency)
                              : fetchPkg::latCnt_t'(fetchPkg::MissLatency);

   // The counter holds the number of request cycles already spent.
   assign latDone = (latCntQ + 1'b1) == latTarget;
   assign capture = memReq.req && !ackQ && latDone;

   // The load port writes the program before fetching starts.
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

   // Returned word and line tag are payload, loaded when ack rises.
   always_ff @(posedge clk) begin
      if (capture) begin
         dataQ     <= mem[wordAddr];
         lastLineQ <= reqLine;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ackQ           <= 1'b0;
         latCntQ        <= '0;
         pendingQ       <= 1'b0;
         lastLineValidQ <= 1'b0;
      end else begin
         // A delivered word clears the pending flag.
         if (fetchedValid) begin
            pendingQ <= 1'b0;
         end
         if (capture) begin
            ackQ           <= 1'b1;
            latCntQ        <= '0;
            pendingQ       <= 1'b1;
            lastLineValidQ <= 1'b1;
         end else if (memReq.req && !ackQ) begin
            latCntQ <= latCntQ + 1'b1;
         end else if (ackQ && !memReq.req) begin
            // Fourth phase, ack follows req down.
            ackQ <= 1'b0;
         end
      end
   end

   // The held word is offered for one cycle as soon as stall is low.
   assign fetchedValid = pendingQ && !stall;
   assign fetchedWord  = dataQ;
   assign memRsp.ack   = ackQ;
   assign memRsp.data  = dataQ;

   ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      $rose(memRsp.ack) |-> memReq.req);

   // While a new word is being fetched, the previous one has already gone to decode.
   noOverwrite: assert property (@(posedge clk) disable iff (!rstN)
      memReq.req && !memRsp.ack |-> !pendingQ);

endmodule
`default_nettype wire

// ==== rtl/pcUnit.sv ====
// Keeps the program counter, picks the next address and runs the four-phase request toward instrMem.
`timescale 1ns/1ps
`default_nettype none
module pcUnit (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           stall,
   input  logic [fetchPkg::AddrWidth-1:0] newPc,
   input  logic                           branchW,
   input  logic                           accept,
   input  logic                           hold,
   input  logic                           halted,
   output fetchPkg::memReq_t              memReq,
   input  logic                           memAck,
   output logic [fetchPkg::AddrWidth-1:0] incPc,
   output logic                           err
);

   // The sequencer walks idle, request, then drain until ack falls again.
   typedef enum logic [1:0] {
      stIdle,
      stReq,
      stDrain
   } seqState_t;

   seqState_t                      state;
   logic [fetchPkg::AddrWidth-1:0] pcQ;
   logic                           resolvedQ;
   logic                           errQ;
   logic                           incOvf;
   logic                           redirectOdd;
   logic                           launch;

   // The increment carries into one extra bit so that a wrap past the top is seen.
   assign {incOvf, incPc} = {1'b0, pcQ} + {{(fetchPkg::AddrWidth-1){1'b0}}, 2'd2};

   // A redirect to an odd byte address cannot hold a 16-bit instruction.
   assign redirectOdd = branchW & newPc[0];

   // A new request starts only once the previous word has been taken or refused.
   // Stall, a delivered halt and a raised error all keep the sequencer idle.
   assign launch = (state == stIdle) & resolvedQ & ~stall & ~halted & ~errQ;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         case (state)
            stIdle: begin
               if (launch) begin
                  state <= stReq;
               end
            end
            stReq: begin
               // Ack high means the data is valid, so req is released.
               if (memAck) begin
                  state <= stDrain;
               end
            end
            stDrain: begin
               // Wait for the store to drop ack before a new req may rise.
               if (!memAck) begin
                  state <= stIdle;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Resolution arrives from hazardDetect as either accept or hold.
   // It starts high so that the first fetch goes out right after reset.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resolvedQ <= 1'b1;
      end else if (launch) begin
         resolvedQ <= 1'b0;
      end else if (accept || hold) begin
         resolvedQ <= 1'b1;
      end
   end

   // On accept the counter moves to the redirect target or the next word.
   // On hold it keeps its value so the same word is fetched again.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pcQ  <= '0;
         errQ <= 1'b0;
      end else if (accept) begin
         pcQ <= branchW ? newPc : incPc;
         if (branchW ? redirectOdd : incOvf) begin
            errQ <= 1'b1;
         end
      end
   end

   assign memReq.req  = (state == stReq);
   assign memReq.addr = pcQ;
   assign err         = errQ;

   // The address seen by the store must not move while a request is open.
   addrStable: assert property (@(posedge clk) disable iff (!rstN)
      memReq.req |=> !memReq.req || $stable(memReq.addr));

   // A new request only rises after the store has finished the previous handshake.
   reqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
      $rose(memReq.req) |-> !memAck);

endmodule
`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module fetchTb -Mdir obj_dir -o fetchSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/fetchSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== src.f ====
rtl/fetchPkg.sv
rtl/pcUnit.sv
rtl/instrMem.sv
rtl/hazardDetect.sv
rtl/fetch.sv
verif/fetchTb.sv

// ==== verif/fetchInput.txt ====
# Program lines: P wordAddr word (hex), written through the load port during reset.
# Vector lines: V rst stageD stageX stageM stageW newPc maxStall instr incPc fwdA fwdB err
# Stages are hex {regWrt, wrtReg, branch, wbSel}; maxStall, rst and err are decimal.
P 00 1141
P 01 1382
P 02 1143
P 03 1264
P 04 1525
P 05 16e6
P 10 1288
P 11 0005
P 12 1a4f
P 20 1007
P 21 1028
P 22 17c9
P 23 12aa
P 24 140b
P 25 136c
P 26 11ed
# Sequential fetch, forwarding, load-use and branch hazards, then stalls and an odd redirect.
V 1 00 00 00 00 0000 0 1141 0002 01 01 0
V 0 00 00 00 00 0000 0 1382 0004 01 01 0
V 0 48 50 00 48 0000 0 1143 0006 02 04 0
V 0 10 68 50 58 0000 0 1264 0008 08 10 0
V 0 69 00 00 00 0000 0 0800 000a 01 01 0
V 0 00 69 00 00 0000 0 1525 000a 04 01 0
V 0 04 00 00 00 0000 0 0800 000c 01 01 0
V 0 00 04 00 00 0000 0 0800 000c 01 01 0
V 0 00 00 04 00 0000 0 0800 000c 01 01 0
V 0 00 00 00 04 0040 0 16e6 000c 01 01 0
V 0 00 00 00 00 0000 4 1007 0042 01 01 0
V 0 00 00 00 00 0000 6 1028 0044 01 01 0
V 0 00 00 00 00 0000 9 17c9 0046 01 01 0
V 0 00 00 00 00 0000 5 12aa 0048 01 01 0
V 0 00 00 00 00 0000 7 140b 004a 01 01 0
V 0 00 00 00 00 0000 3 136c 004c 01 01 0
V 0 00 00 00 04 0051 2 11ed 004e 01 01 1
# After a fresh reset, redirect to the halt and check that fetching stops.
V 1 00 00 00 04 0020 0 1141 0002 01 01 0
V 0 00 00 00 00 0000 8 1288 0022 01 01 0
V 0 41 40 00 00 0000 0 0005 0024 01 01 0

// ==== verif/fetchTb.sv ====
// Testbench for the fetch stage; loads the program, replays the vectors of the input file and checks each word.
`timescale 1ns/1ps
module fetchTb;

   localparam int ClkPeriod      = 8;
   localparam int ResetCycles    = 16;
   localparam int DriveDelay     = 1;
   // Long enough for a refetch to reach decode if fetching had not stopped.
   localparam int QuietCycles    = 3 * (fetchPkg::MissLatency + 4);

   // One word of the program image.
   typedef struct packed {
      logic [fetchPkg::MemAddrWidth-1:0] addr;
      logic [fetchPkg::InstrWidth-1:0]   word;
   } progEntry_t;

   // One vector: the stage status to drive and the word expected at the next valid.
   typedef struct packed {
      logic                           rst;
      fetchPkg::stageInfo_t           stageD;
      fetchPkg::stageInfo_t           stageX;
      fetchPkg::stageInfo_t           stageM;
      fetchPkg::stageInfo_t           stageW;
      logic [fetchPkg::AddrWidth-1:0] newPc;
      logic [7:0]                     maxStall;
      logic [fetchPkg::InstrWidth-1:0] instr;
      logic [fetchPkg::AddrWidth-1:0] incPc;
      logic [4:0]                     fwdA;
      logic [4:0]                     fwdB;
      logic                           err;
   } vector_t;

   logic                              clk = 1'b0;
   logic                              rstN;
   logic                              stall;
   logic [fetchPkg::AddrWidth-1:0]    newPc;
   fetchPkg::stageInfo_t              stageD;
   fetchPkg::stageInfo_t              stageX;
   fetchPkg::stageInfo_t              stageM;
   fetchPkg::stageInfo_t              stageW;
   logic                              loadEn;
   logic [fetchPkg::MemAddrWidth-1:0] loadAddr;
   logic [fetchPkg::InstrWidth-1:0]   loadData;
   fetchPkg::fetchOut_t               fetchOut;
   fetchPkg::fwdSel_t                 fwdA;
   fetchPkg::fwdSel_t                 fwdB;
   logic                              err;

   progEntry_t progWords[$];
   vector_t    vectors[$];
   int         errorCount   = 0;
   int         testCount    = 0;
   int         failCount    = 0;
   int         validCount   = 0;
   int         largestStall = 0;
   int         resetCount   = 0;
   int         stopCount    = 0;
   int         cycleLimit   = 0;
   logic       limitReady   = 1'b0;

   fetch u_dut (
      .clk(clk), .rstN(rstN), .stall(stall), .newPc(newPc),
      .stageD(stageD), .stageX(stageX), .stageM(stageM), .stageW(stageW),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .fetchOut(fetchOut), .fwdA(fwdA), .fwdB(fwdB), .err(err)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   // Every end marker is counted, so a dropped or repeated word shows in the total.
   always @(negedge clk) begin
      if (rstN && fetchOut.valid) begin
         validCount++;
      end
   end

   // A delivered halt or a raised error must stop all further fetching.
   function automatic logic stopsFetch(input vector_t v);
      return v.err || (v.instr[fetchPkg::InstrWidth-1 -: fetchPkg::OpcodeWidth] == fetchPkg::OpHalt);
   endfunction

   task automatic compareField(input string what, input logic [15:0] got,
                               input logic [15:0] expected, input int testNum);
      if (got !== expected) begin
         $display("Error at %0d ns: test %0d %s is %h, expected %h",
                  $time, testNum, what, got, expected);
         errorCount++;
      end
   endtask

   // Outputs must sit at their reset values while rstN is low.
   task automatic checkResetState();
      int errorsBefore;
      errorsBefore = errorCount;
      @(negedge clk);
      compareField("valid in reset", {15'b0, fetchOut.valid}, 16'h0000, 0);
      compareField("err in reset", {15'b0, err}, 16'h0000, 0);
      compareField("fwdA in reset", {11'b0, fwdA}, {11'b0, fetchPkg::fwdNone}, 0);
      compareField("fwdB in reset", {11'b0, fwdB}, {11'b0, fetchPkg::fwdNone}, 0);
      testCount++;
      if (errorCount == errorsBefore) begin
         $display("Reset check: ok");
      end else begin
         failCount++;
         $display("Reset check: FAILED");
      end
      @(posedge clk);
      #DriveDelay;
   endtask

   // Reads program lines (P) and vector lines (V); lines starting with # are skipped.
   task automatic readInput();
      int    fd;
      int    rstIn;
      int    errIn;
      string line;
      string body;
      logic [7:0]  addrIn;
      logic [15:0] wordIn;
      logic [6:0]  dIn, xIn, mIn, wIn;
      logic [15:0] pcIn, instrIn, incIn;
      logic [7:0]  stallIn;
      logic [4:0]  faIn, fbIn;
      vector_t     v;
      fd = $fopen("verif/fetchInput.txt", "r");
      if (fd == 0) begin
         $display("Cannot open verif/fetchInput.txt, so there is no stimulus to run");
         $display("Testbench failed");
         $finish;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         body = line.substr(1, line.len() - 1);
         if (line.getc(0) == "P" && $sscanf(body, "%h %h", addrIn, wordIn) == 2) begin
            progWords.push_back('{addr: addrIn, word: wordIn});
         end else if (line.getc(0) == "V" &&
                      $sscanf(body, "%d %h %h %h %h %h %d %h %h %h %h %d", rstIn, dIn, xIn,
                              mIn, wIn, pcIn, stallIn, instrIn, incIn, faIn, fbIn, errIn) == 12) begin
            v = '{rst: rstIn != 0, stageD: dIn, stageX: xIn, stageM: mIn, stageW: wIn,
                  newPc: pcIn, maxStall: stallIn, instr: instrIn, incPc: incIn,
                  fwdA: faIn, fwdB: fbIn, err: errIn != 0};
            vectors.push_back(v);
            if (int'(stallIn) > largestStall) begin
               largestStall = int'(stallIn);
            end
            if (v.rst) begin
               resetCount++;
            end
            if (stopsFetch(v)) begin
               stopCount++;
            end
         end else begin
            $display("Malformed line in the input file: %s", line);
            errorCount++;
         end
      end
      $fclose(fd);
   endtask

   // Drives one vector, waits for the end marker and checks the delivered word.
   task automatic runVector(input int idx);
      vector_t v;
      int      stallLen;
      int      errorsBefore;
      v = vectors[idx];
      errorsBefore = errorCount;
      stageD = v.stageD;
      stageX = v.stageX;
      stageM = v.stageM;
      stageW = v.stageW;
      newPc  = v.newPc;
      stall  = 1'b0;
      // A later segment starts from a fresh reset, with the new status already applied.
      if (v.rst && idx > 0) begin
         rstN = 1'b0;
         repeat (ResetCycles) @(posedge clk);
         #DriveDelay;
         checkResetState();
      end
      rstN = 1'b1;
      // The stall rises before the word can reach decode, so it catches the handshake in flight.
      stallLen = $urandom % (int'(v.maxStall) + 1);
      if (stallLen > 0) begin
         stall = 1'b1;
         repeat (stallLen) @(posedge clk);
         #DriveDelay;
         stall = 1'b0;
      end
      do begin
         @(negedge clk);
      end while (!fetchOut.valid);
      compareField("instr", fetchOut.instr, v.instr, idx + 1);
      compareField("incPc", fetchOut.incPc, v.incPc, idx + 1);
      compareField("fwdA", {11'b0, fwdA}, {11'b0, v.fwdA}, idx + 1);
      compareField("fwdB", {11'b0, fwdB}, {11'b0, v.fwdB}, idx + 1);
      compareField("err", {15'b0, err}, {15'b0, v.err}, idx + 1);
      if (stopsFetch(v)) begin
         repeat (QuietCycles) begin
            @(negedge clk);
            if (fetchOut.valid) begin
               $display("Error at %0d ns: test %0d a word arrived after fetching should have stopped",
                        $time, idx + 1);
               errorCount++;
            end
         end
      end
      @(posedge clk);
      #DriveDelay;
      testCount++;
      if (errorCount == errorsBefore) begin
         $display("Test %0d: ok, stall %0d cycles, instr %h", idx + 1, stallLen, v.instr);
      end else begin
         failCount++;
         $display("Test %0d: FAILED, stall %0d cycles, instr %h", idx + 1, stallLen, v.instr);
      end
   endtask

   initial begin
      int loadCycles;
      rstN     = 1'b0;
      stall    = 1'b0;
      newPc    = '0;
      stageD   = '0;
      stageX   = '0;
      stageM   = '0;
      stageW   = '0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      void'($urandom(32'hefc5));
      readInput();
      cycleLimit = ResetCycles + progWords.size() + resetCount * (ResetCycles + 4) +
                   stopCount * QuietCycles +
                   vectors.size() * (fetchPkg::MissLatency + largestStall + 10);
      limitReady = 1'b1;
      // The program goes in through the load port while the stage is held in reset.
      loadCycles = (progWords.size() > ResetCycles) ? progWords.size() : ResetCycles;
      @(posedge clk);
      #DriveDelay;
      for (int i = 0; i < loadCycles; i++) begin
         if (i < progWords.size()) begin
            loadEn   = 1'b1;
            loadAddr = progWords[i].addr;
            loadData = progWords[i].word;
         end else begin
            loadEn = 1'b0;
         end
         @(posedge clk);
         #DriveDelay;
      end
      loadEn = 1'b0;
      checkResetState();
      foreach (vectors[i]) begin
         runVector(i);
      end
      if (validCount != vectors.size()) begin
         $display("Error at %0d ns: %0d words delivered, expected %0d",
                  $time, validCount, vectors.size());
         errorCount++;
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
               testCount, testCount - failCount, failCount, errorCount);
      if (errorCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Ends a run that stops making progress.
   initial begin
      wait (limitReady);
      repeat (cycleLimit) @(posedge clk);
      $display("Timed out after %0d cycles while waiting for the next fetched word", cycleLimit);
      $display("Testbench failed");
      $finish;
   end

endmodule
